/* logic/link_pkg.sv */
/*
  Wormhole link definitions shared by the flit deserializer, the flit
  serializer and the response header encoder. A link carries one flit per
  cycle downstream, and its ready bit travels back as a separate port.
*/
`default_nettype none

package link_pkg;

  localparam int flit_width_lp = 32;
  localparam int cord_width_lp = 4;
  localparam int cid_width_lp  = 2;
  localparam int len_width_lp  = 3;

  // len counts the data flits that follow the header flit.
  typedef struct packed {
    logic [len_width_lp-1:0]  len;
    logic [cord_width_lp-1:0] cord;
    logic [cid_width_lp-1:0]  cid;
  } wh_header_s;

  localparam int wh_header_width_lp = $bits(wh_header_s);

  typedef struct packed {
    logic                     v;
    logic [flit_width_lp-1:0] data;
  } link_s;

endpackage

`default_nettype wire

/* logic/mem_msg_pkg.sv */
/*
  Memory message definitions: command and response headers, block size,
  payload masks and the packet that crosses the link in both directions.
  The header flit holds the wormhole header in its low bits, the memory
  header above it and zero in the remaining bits.
*/
`default_nettype none

package mem_msg_pkg;
  import link_pkg::*;

  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_msg_e;

  // size n means n+1 data words.
  typedef struct packed {
    mem_msg_e    msg_type;
    logic [15:0] addr;
    logic [1:0]  size;
  } mem_hdr_s;

  localparam int mem_hdr_width_lp   = $bits(mem_hdr_s);
  localparam int hdr_flit_pad_lp    = flit_width_lp - wh_header_width_lp - mem_hdr_width_lp;
  localparam int mem_word_width_lp  = 32;
  localparam int block_words_lp     = 4;
  localparam int block_width_lp     = block_words_lp * mem_word_width_lp;
  localparam int mem_words_lp       = 256;
  localparam int mem_idx_width_lp   = $clog2(mem_words_lp);

  // indexed by msg_type; a set bit means the message carries data.
  localparam logic [3:0] mem_cmd_payload_mask_lp  = 4'b0010;
  localparam logic [3:0] mem_resp_payload_mask_lp = 4'b0001;

  typedef struct packed {
    wh_header_s                header;
    mem_hdr_s                  msg_hdr;
    logic [block_width_lp-1:0] data;
  } mem_packet_s;

endpackage

`default_nettype wire

/* logic/link_flit_deserializer.sv */
/*
  Collects a header flit and the data flits that follow it into one
  memory packet. The packet is offered with v_o and held until yumi_i;
  no new flit is accepted while a packet is held.
*/
`timescale 1ns/1ps
`default_nettype none

module link_flit_deserializer
  import link_pkg::*;
  import mem_msg_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  link_s       link_i,
  output logic        ready_o,
  output mem_packet_s packet_o,
  output logic        v_o,
  input  wire         yumi_i
);

  mem_packet_s             packet_r;
  wh_header_s              hdr_flit;
  logic                    collect_r;
  logic                    v_r;
  logic [len_width_lp-1:0] cnt_r;
  logic                    link_fire;

  assign ready_o   = ~v_r;
  assign link_fire = link_i.v & ready_o;
  assign hdr_flit  = link_i.data[wh_header_width_lp-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      collect_r <= 1'b0;
      v_r       <= 1'b0;
      cnt_r     <= '0;
    end else begin
      if (v_r && yumi_i) begin
        v_r <= 1'b0;
      end
      if (link_fire) begin
        if (!collect_r) begin
          cnt_r <= '0;
          if (hdr_flit.len == '0) begin
            v_r <= 1'b1;
          end else begin
            collect_r <= 1'b1;
          end
        end else begin
          cnt_r <= cnt_r + 1'b1;
          // the last data flit completes the packet.
          if (cnt_r == packet_r.header.len - 1'b1) begin
            collect_r <= 1'b0;
            v_r       <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (link_fire) begin
      if (!collect_r) begin
        packet_r.header  <= hdr_flit;
        packet_r.msg_hdr <= link_i.data[wh_header_width_lp +: mem_hdr_width_lp];
        packet_r.data    <= '0;
      end else begin
        packet_r.data[cnt_r[1:0]*flit_width_lp +: flit_width_lp] <= link_i.data;
      end
    end
  end

  assign packet_o = packet_r;
  assign v_o      = v_r;

endmodule

`default_nettype wire

/* logic/link_flit_serializer.sv */
/*
  Breaks one memory packet into a header flit and its data flits. It holds
  a single packet and accepts the next only after the final flit has left.
  A low ready_i stalls the current flit in place.
*/
`timescale 1ns/1ps
`default_nettype none

module link_flit_serializer
  import link_pkg::*;
  import mem_msg_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  mem_packet_s packet_i,
  input  wire         v_i,
  output logic        ready_and_o,
  output link_s       link_o,
  input  wire         ready_i
);

  mem_packet_s             packet_r;
  logic                    busy_r;
  logic                    hdr_pending_r;
  logic [len_width_lp-1:0] left_r;
  logic [1:0]              word_idx;
  logic                    accept;
  logic                    flit_fire;

  assign ready_and_o = ~busy_r;
  assign accept      = v_i & ready_and_o;
  assign flit_fire   = busy_r & ready_i;
  assign word_idx    = 2'(packet_r.header.len - left_r);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_r        <= 1'b0;
      hdr_pending_r <= 1'b0;
      left_r        <= '0;
    end else if (accept) begin
      busy_r        <= 1'b1;
      hdr_pending_r <= 1'b1;
      left_r        <= packet_i.header.len;
    end else if (flit_fire) begin
      if (hdr_pending_r) begin
        hdr_pending_r <= 1'b0;
        if (left_r == '0) begin
          busy_r <= 1'b0;
        end
      end else begin
        left_r <= left_r - 1'b1;
        if (left_r == len_width_lp'(1)) begin
          busy_r <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      packet_r <= packet_i;
    end
  end

  // ##################################################
  // outgoing flit
  assign link_o.v    = busy_r;
  assign link_o.data = hdr_pending_r
                       ? {{hdr_flit_pad_lp{1'b0}}, packet_r.msg_hdr, packet_r.header}
                       : packet_r.data[word_idx*flit_width_lp +: flit_width_lp];

endmodule

`default_nettype wire

/* logic/mem_resp_encoder.sv */
/*
  Forms the wormhole header of a memory response. Responses that carry
  data get len size+1, all others a lone header flit. The destination
  comes straight from the node's configuration inputs.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_resp_encoder
  import link_pkg::*;
  import mem_msg_pkg::*;
(
  input  mem_hdr_s                 mem_hdr_i,
  input  wire [cord_width_lp-1:0]  dst_cord_i,
  input  wire [cid_width_lp-1:0]   dst_cid_i,
  output wh_header_s               wh_header_o
);

  logic has_payload;

  assign has_payload = mem_resp_payload_mask_lp[mem_hdr_i.msg_type];

  always_comb begin
    wh_header_o.cord = dst_cord_i;
    wh_header_o.cid  = dst_cid_i;
    if (has_payload) begin
      wh_header_o.len = len_width_lp'(mem_hdr_i.size) + 1'b1;
    end else begin
      wh_header_o.len = '0;
    end
  end

endmodule

`default_nettype wire

/* logic/mem_link_recv.sv */
/*
  Memory-side link receiver. Command flits are gathered into a memory
  command, and each memory response is wrapped in a fresh wormhole header
  and sent back out as flits. No buffering beyond the two converters.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_link_recv
  import link_pkg::*;
  import mem_msg_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire [cord_width_lp-1:0]  dst_cord_i,
  input  wire [cid_width_lp-1:0]   dst_cid_i,
  input  link_s                    cmd_link_i,
  output logic                     cmd_ready_o,
  output link_s                    resp_link_o,
  input  wire                      resp_ready_i,
  output mem_hdr_s                 mem_cmd_hdr_o,
  output logic [block_width_lp-1:0] mem_cmd_data_o,
  output logic                     mem_cmd_v_o,
  input  wire                      mem_cmd_yumi_i,
  input  mem_hdr_s                 mem_resp_hdr_i,
  input  wire [block_width_lp-1:0] mem_resp_data_i,
  input  wire                      mem_resp_v_i,
  output logic                     mem_resp_ready_and_o
);

  mem_packet_s mem_cmd_packet;
  mem_packet_s mem_resp_packet;
  wh_header_s  resp_wh_header;

  link_flit_deserializer cmd_deser (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .link_i   (cmd_link_i),
    .ready_o  (cmd_ready_o),
    .packet_o (mem_cmd_packet),
    .v_o      (mem_cmd_v_o),
    .yumi_i   (mem_cmd_yumi_i)
  );

  assign mem_cmd_hdr_o  = mem_cmd_packet.msg_hdr;
  assign mem_cmd_data_o = mem_cmd_packet.data;

  mem_resp_encoder resp_enc (
    .mem_hdr_i   (mem_resp_hdr_i),
    .dst_cord_i  (dst_cord_i),
    .dst_cid_i   (dst_cid_i),
    .wh_header_o (resp_wh_header)
  );

  assign mem_resp_packet = '{header: resp_wh_header, msg_hdr: mem_resp_hdr_i,
                             data: mem_resp_data_i};

  link_flit_serializer resp_ser (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .packet_i    (mem_resp_packet),
    .v_i         (mem_resp_v_i),
    .ready_and_o (mem_resp_ready_and_o),
    .link_o      (resp_link_o),
    .ready_i     (resp_ready_i)
  );

endmodule

`default_nettype wire

/* logic/block_mem.sv */
/*
  Word memory of 256 x 32 bits serving reads and writes of one to four
  words. Each accepted command yields one response that echoes the command
  header; read data sits in the low words with zero above.
*/
`timescale 1ns/1ps
`default_nettype none

module block_mem
  import mem_msg_pkg::*;
(
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  mem_hdr_s                  cmd_hdr_i,
  input  wire [block_width_lp-1:0]  cmd_data_i,
  input  wire                       cmd_v_i,
  output logic                      cmd_yumi_o,
  output mem_hdr_s                  resp_hdr_o,
  output logic [block_width_lp-1:0] resp_data_o,
  output logic                      resp_v_o,
  input  wire                       resp_ready_and_i
);

  logic [mem_word_width_lp-1:0] mem_r [mem_words_lp];
  mem_hdr_s                     resp_hdr_r;
  logic [block_width_lp-1:0]    resp_data_r;
  logic                         resp_v_r;

  // one response slot, so a command waits while a response is pending.
  assign cmd_yumi_o = cmd_v_i & ~resp_v_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_r <= 1'b0;
    end else if (cmd_yumi_o) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_and_i) begin
      resp_v_r <= 1'b0;
    end
  end

  // ##################################################
  // storage access
  always_ff @(posedge clk_i) begin
    if (cmd_yumi_o) begin
      resp_hdr_r <= cmd_hdr_i;
      for (int k = 0; k < block_words_lp; k++) begin
        if (k <= cmd_hdr_i.size && cmd_hdr_i.msg_type == e_mem_wr) begin
          mem_r[mem_idx_width_lp'(cmd_hdr_i.addr + k)]
            <= cmd_data_i[k*mem_word_width_lp +: mem_word_width_lp];
        end
        if (k <= cmd_hdr_i.size && cmd_hdr_i.msg_type == e_mem_rd) begin
          resp_data_r[k*mem_word_width_lp +: mem_word_width_lp]
            <= mem_r[mem_idx_width_lp'(cmd_hdr_i.addr + k)];
        end else begin
          resp_data_r[k*mem_word_width_lp +: mem_word_width_lp] <= '0;
        end
      end
    end
  end

  assign resp_hdr_o  = resp_hdr_r;
  assign resp_data_o = resp_data_r;
  assign resp_v_o    = resp_v_r;

endmodule

`default_nettype wire

/* logic/mem_link_node.sv */
/*
  Top level of the memory-side link node. Command flits in, response
  flits out; dst_cord_i and dst_cid_i say where responses are sent.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_link_node
  import link_pkg::*;
  import mem_msg_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire [cord_width_lp-1:0] dst_cord_i,
  input  wire [cid_width_lp-1:0]  dst_cid_i,
  input  link_s                   cmd_link_i,
  output logic                    cmd_ready_o,
  output link_s                   resp_link_o,
  input  wire                     resp_ready_i
);

  mem_hdr_s                  mem_cmd_hdr;
  logic [block_width_lp-1:0] mem_cmd_data;
  logic                      mem_cmd_v;
  logic                      mem_cmd_yumi;
  mem_hdr_s                  mem_resp_hdr;
  logic [block_width_lp-1:0] mem_resp_data;
  logic                      mem_resp_v;
  logic                      mem_resp_ready_and;

  mem_link_recv recv (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .dst_cord_i           (dst_cord_i),
    .dst_cid_i            (dst_cid_i),
    .cmd_link_i           (cmd_link_i),
    .cmd_ready_o          (cmd_ready_o),
    .resp_link_o          (resp_link_o),
    .resp_ready_i         (resp_ready_i),
    .mem_cmd_hdr_o        (mem_cmd_hdr),
    .mem_cmd_data_o       (mem_cmd_data),
    .mem_cmd_v_o          (mem_cmd_v),
    .mem_cmd_yumi_i       (mem_cmd_yumi),
    .mem_resp_hdr_i       (mem_resp_hdr),
    .mem_resp_data_i      (mem_resp_data),
    .mem_resp_v_i         (mem_resp_v),
    .mem_resp_ready_and_o (mem_resp_ready_and)
  );

  block_mem mem (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .cmd_hdr_i        (mem_cmd_hdr),
    .cmd_data_i       (mem_cmd_data),
    .cmd_v_i          (mem_cmd_v),
    .cmd_yumi_o       (mem_cmd_yumi),
    .resp_hdr_o       (mem_resp_hdr),
    .resp_data_o      (mem_resp_data),
    .resp_v_o         (mem_resp_v),
    .resp_ready_and_i (mem_resp_ready_and)
  );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
/*
  Testbench clock and reset source. The clock has an 8 ns period and the
  reset stays high for the first 8 rising edges.
*/
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* verif/mem_link_node_tb.sv */
/*
  Directed testbench for the memory link node. Command flits are driven on
  the falling edge and response flits are collected and compared with a
  model memory. Covers reset state, write/read pairs of every size,
  address wrap and response back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_link_node_tb
  import link_pkg::*;
  import mem_msg_pkg::*;
();

  logic                     clk;
  logic                     rst;
  logic [cord_width_lp-1:0] dst_cord;
  logic [cid_width_lp-1:0]  dst_cid;
  link_s                    cmd_link;
  logic                     cmd_ready;
  link_s                    resp_link;
  logic                     resp_ready;

  logic [31:0] model_mem [mem_words_lp];
  logic [31:0] resp_flits [$];
  integer      seed = 32'h9ff3a5f0;
  int          held_cycles;
  int          timeout_cycles = 200;

  clk_gen clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_link_node UUT (
    .clk_i        (clk),
    .rst_i        (rst),
    .dst_cord_i   (dst_cord),
    .dst_cid_i    (dst_cid),
    .cmd_link_i   (cmd_link),
    .cmd_ready_o  (cmd_ready),
    .resp_link_o  (resp_link),
    .resp_ready_i (resp_ready)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  function automatic logic [block_width_lp-1:0] model_block(input logic [15:0] addr,
                                                            input logic [1:0] size);
    logic [block_width_lp-1:0] blk;
    blk = '0;
    for (int k = 0; k <= size; k++) begin
      blk[k*32 +: 32] = model_mem[8'(addr + k)];
    end
    return blk;
  endfunction

  // ##################################################
  // link drivers

  task automatic send_cmd(input mem_hdr_s hdr, input logic [block_width_lp-1:0] data);
    logic [31:0] flits [$];
    wh_header_s  wh;
    int          waited;
    // commands carry data only for writes.
    wh.len  = (hdr.msg_type == e_mem_wr) ? {1'b0, hdr.size} + 3'd1 : 3'd0;
    wh.cord = 4'($random(seed));
    wh.cid  = 2'($random(seed));
    flits.push_back({3'b000, hdr, wh});
    for (int k = 0; k < wh.len; k++) begin
      flits.push_back(data[k*32 +: 32]);
    end
    foreach (flits[i]) begin
      waited = 0;
      @(negedge clk);
      cmd_link = '{v: 1'b1, data: flits[i]};
      while (!cmd_ready) begin
        held_cycles++;
        waited++;
        if (waited > timeout_cycles) begin
          abort_run("command flit was not accepted before the timeout");
        end
        @(negedge clk);
      end
    end
    @(negedge clk);
    cmd_link.v = 1'b0;
  endtask

  task automatic recv_resp(input bit stall);
    int need;
    int waited;
    resp_flits.delete();
    need   = 1;
    waited = 0;
    while (resp_flits.size() < need) begin
      @(negedge clk);
      resp_ready = !stall || ($random(seed) % 4 != 0);
      if (resp_link.v && resp_ready) begin
        if (resp_flits.size() == 0) begin
          need = 1 + resp_link.data[8:6];
        end
        resp_flits.push_back(resp_link.data);
        waited = 0;
      end else begin
        waited++;
        if (waited > timeout_cycles) begin
          abort_run("response flit did not arrive before the timeout");
        end
      end
    end
  endtask

  task automatic check_resp(input mem_hdr_s hdr, input logic [block_width_lp-1:0] exp_data);
    logic [len_width_lp-1:0] len;
    logic [31:0]             exp_hdr;
    len     = (hdr.msg_type == e_mem_rd) ? {1'b0, hdr.size} + 3'd1 : 3'd0;
    exp_hdr = {3'b000, hdr, len, dst_cord, dst_cid};
    assert (resp_flits.size() == len + 1)
      else report_mismatch("response flit count", resp_flits.size(), len + 1);
    assert (resp_flits[0] === exp_hdr)
      else report_mismatch("resp_link_o.data header flit", resp_flits[0], exp_hdr);
    for (int k = 0; k < len; k++) begin
      assert (resp_flits[k+1] === exp_data[k*32 +: 32])
        else report_mismatch($sformatf("resp_link_o.data word %0d", k),
                             resp_flits[k+1], exp_data[k*32 +: 32]);
    end
  endtask

  task automatic set_dst();
    @(negedge clk);
    dst_cord = 4'($random(seed));
    dst_cid  = 2'($random(seed));
  endtask

  task automatic write_words(input logic [15:0] addr, input logic [1:0] size);
    mem_hdr_s                  hdr;
    logic [block_width_lp-1:0] data;
    hdr  = '{msg_type: e_mem_wr, addr: addr, size: size};
    data = '0;
    for (int k = 0; k <= size; k++) begin
      data[k*32 +: 32]         = $random(seed);
      model_mem[8'(addr + k)] = data[k*32 +: 32];
    end
    send_cmd(hdr, data);
    recv_resp(1'b0);
    check_resp(hdr, '0);
  endtask

  task automatic read_words(input logic [15:0] addr, input logic [1:0] size);
    mem_hdr_s hdr;
    hdr = '{msg_type: e_mem_rd, addr: addr, size: size};
    send_cmd(hdr, '0);
    recv_resp(1'b0);
    check_resp(hdr, model_block(addr, size));
  endtask

  // ##################################################
  // directed tests

  task automatic test_reset_state();
    assert (cmd_ready === 1'b1) else report_mismatch("cmd_ready_o", cmd_ready, 1);
    repeat (10) begin
      @(negedge clk);
      assert (resp_link.v === 1'b0)
        else report_mismatch("resp_link_o.v", resp_link.v, 0);
    end
  endtask

  task automatic test_write_read();
    logic [15:0] addr;
    for (int size = 0; size < block_words_lp; size++) begin
      set_dst();
      addr = 16'($random(seed));
      write_words(addr, 2'(size));
      read_words(addr, 2'(size));
    end
  endtask

  task automatic test_wrap();
    set_dst();
    write_words(16'd254, 2'd3);
    read_words(16'd254, 2'd3);
    read_words(16'd0, 2'd0);
    read_words(16'd1, 2'd0);
  endtask

  task automatic test_back_pressure();
    mem_hdr_s                  hdr_a;
    mem_hdr_s                  hdr_b;
    mem_hdr_s                  hdr_c;
    mem_hdr_s                  hdr_d;
    logic [block_width_lp-1:0] exp_a;
    logic [block_width_lp-1:0] exp_b;
    logic [block_width_lp-1:0] data_c;
    write_words(16'h0010, 2'd3);
    set_dst();
    hdr_a  = '{msg_type: e_mem_rd, addr: 16'h0010, size: 2'd3};
    hdr_b  = '{msg_type: e_mem_rd, addr: 16'h00fe, size: 2'd2};
    hdr_c  = '{msg_type: e_mem_wr, addr: 16'h0040, size: 2'd3};
    hdr_d  = '{msg_type: e_mem_rd, addr: 16'h0040, size: 2'd3};
    exp_a  = model_block(hdr_a.addr, hdr_a.size);
    exp_b  = model_block(hdr_b.addr, hdr_b.size);
    data_c = {$random(seed), $random(seed), $random(seed), $random(seed)};
    for (int k = 0; k < block_words_lp; k++) begin
      model_mem[8'(hdr_c.addr + k)] = data_c[k*32 +: 32];
    end
    held_cycles = 0;
    fork
      begin
        send_cmd(hdr_a, '0);
        send_cmd(hdr_b, '0);
        send_cmd(hdr_c, data_c);
        send_cmd(hdr_d, '0);
      end
      begin
        // a stalled response path fills every stage, so later commands back up.
        @(negedge clk);
        resp_ready = 1'b0;
        repeat (24) @(negedge clk);
        recv_resp(1'b1);
        check_resp(hdr_a, exp_a);
        recv_resp(1'b1);
        check_resp(hdr_b, exp_b);
        recv_resp(1'b1);
        check_resp(hdr_c, '0);
        recv_resp(1'b1);
        check_resp(hdr_d, data_c);
      end
    join
    assert (held_cycles > 0)
      else abort_run("cmd_ready_o never held off a command during the stall");
    @(negedge clk);
    resp_ready = 1'b1;
  endtask

  initial begin
    int waited;
    held_cycles = 0;
    cmd_link    = '0;
    resp_ready  = 1'b1;
    dst_cord    = '0;
    dst_cid     = '0;
    waited      = 0;
    while (rst !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) begin
        abort_run("reset was not released");
      end
    end
    test_reset_state();
    test_write_read();
    test_wrap();
    test_back_pressure();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
logic/link_pkg.sv
logic/mem_msg_pkg.sv
logic/link_flit_deserializer.sv
logic/link_flit_serializer.sv
logic/mem_resp_encoder.sv
logic/mem_link_recv.sv
logic/block_mem.sv
logic/mem_link_node.sv
verif/clk_gen.sv
verif/mem_link_node_tb.sv
